// ==== sources.f ====
verilog/sha_pkg.sv
verilog/sha_stage_if.sv
verilog/sha_midstate_front.sv
verilog/sha_super_pipelined_pre_pipeline.sv
verilog/sha_super_pipelined_stage.sv
verilog/sha_super_pipelined_preserve_history_stage.sv
verilog/sha_super_pipelined_pad_hash.sv
verilog/sha_super_pipelined_core.sv
verilog/sha_miner_top.sv
tests/sha_checker.sv
tests/tb_sha_miner.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the double SHA-256 miner testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_sha_miner -o sim_tb_sha_miner
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_sha_miner)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// ==== tests/tb_sha_miner.sv ====
`timescale 1ns/100ps

module tb_sha_miner;

  localparam int CLK_NS  = 4;
  localparam int LATENCY = 129; // Front to hash_valid_o, in cycles.
  localparam int N_CONT  = 200; // Nonces in the continuous run.
  localparam int N_GAP   = 240; // Cycles of LFSR-gated run_i.
  localparam int N_OLD   = 100; // Old-job nonces before the mid-stream load.
  localparam int N_NEW   = 40;
  localparam int N_TESTS = 5;
  // Every issue slot plus one drain per test, doubled for margin.
  localparam int RUN_LIMIT_NS = 2 * CLK_NS
      * (1 + N_CONT + N_GAP + N_OLD + N_NEW + N_TESTS * (LATENCY + 24) + 16);
  localparam logic [255:0] FIXED_MID = {
    32'h9524c593, 32'h05c56713, 32'h16e669ba, 32'h2d2810a0,
    32'h07e86e37, 32'h2f56a9da, 32'hcd5bce69, 32'h7a78da2d
  };

  logic         clk;
  logic         rst_n;
  logic         job_valid;
  logic [255:0] midstate;
  logic [31:0]  merkle_tail;
  logic [31:0]  timestamp;
  logic [31:0]  bits;
  logic         run;
  logic         hash_valid;
  logic         newblock;
  logic [255:0] hash;
  int           test_id;
  logic         end_test;
  int           issued;       // Items the front has sampled with run_i high.
  int           hashes;
  int           errors;
  int           tests_failed;
  logic [31:0]  lfsr;

  sha_miner_top uut (
    .clk(clk), .rst_n_i(rst_n), .job_valid_i(job_valid), .midstate_i(midstate),
    .merkle_tail_i(merkle_tail), .timestamp_i(timestamp), .bits_i(bits), .run_i(run),
    .hash_valid_o(hash_valid), .newblock_o(newblock), .hash_o(hash)
  );

  sha_checker u_check (
    .clk(clk), .rst_n_i(rst_n), .job_valid_i(job_valid), .midstate_i(midstate),
    .merkle_tail_i(merkle_tail), .timestamp_i(timestamp), .bits_i(bits), .run_i(run),
    .hash_valid_i(hash_valid), .newblock_i(newblock), .hash_i(hash),
    .test_id_i(test_id), .end_test_i(end_test), .issued_i(issued),
    .hashes_o(hashes), .errors_o(errors), .tests_failed_o(tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1, one new bit per call.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]}; // One step per bit taken.
    end
  endtask

  // Called right after a rising edge, like every task below.
  task automatic load_job(input logic [255:0] m, input logic [31:0] t,
                          input logic [31:0] ts, input logic [31:0] b);
    job_valid   <= 1'b1;
    midstate    <= m;
    merkle_tail <= t;
    timestamp   <= ts;
    bits        <= b;
    @(posedge clk);
    job_valid <= 1'b0;
  endtask

  task automatic load_random_job();
    logic [255:0] m;
    logic [31:0]  wd;
    logic [31:0]  t;
    logic [31:0]  ts;
    logic [31:0]  b;
    for (int i = 0; i < 8; i++) begin
      random_word(wd);
      m = {m[223:0], wd};
    end
    random_word(t);
    random_word(ts);
    random_word(b);
    load_job(m, t, ts, b);
  endtask

  // Holds run_i high for n cycles, or LFSR-gated when gaps is set.
  task automatic run_cycles(input int n, input logic gaps);
    logic go;
    for (int i = 0; i < n; i++) begin
      go = 1'b1;
      if (gaps) begin
        lfsr = lfsr_step(lfsr);
        go = lfsr[0];
      end
      run <= go;
      if (go) issued++;
      @(posedge clk);
    end
    run <= 1'b0;
  endtask

  // Waits for every issued item to come out, then lets the checker close the test.
  task automatic close_test();
    while (hashes < issued) @(posedge clk);
    repeat (4) @(posedge clk); // Room for a surplus hash to show up.
    end_test <= 1'b1;
    @(posedge clk);
    end_test <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    lfsr        = 32'd18;
    rst_n       = 1'b0;
    job_valid   = 1'b0;
    midstate    = '0;
    merkle_tail = '0;
    timestamp   = '0;
    bits        = '0;
    run         = 1'b0;
    test_id     = 0;
    end_test    = 1'b0;
    issued      = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    repeat (40) @(posedge clk); // Idle pipeline, nothing may leave it.
    close_test();

    test_id <= 1;
    load_job(FIXED_MID, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d);
    run_cycles(1, 1'b0);
    close_test();

    test_id <= 2;
    load_random_job();
    run_cycles(N_CONT, 1'b0);
    close_test();

    test_id <= 3;
    load_random_job();
    run_cycles(N_GAP, 1'b1);
    close_test();

    test_id <= 4;
    load_random_job();
    run_cycles(N_OLD, 1'b0);
    load_random_job(); // Old items are still deep in the pipeline here.
    run_cycles(N_NEW, 1'b0);
    close_test();

    $display("summary: %0d tests, %0d failed, %0d hashes checked, %0d errors",
             N_TESTS, tests_failed, hashes, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(RUN_LIMIT_NS);
    $display("timeout: %0d of %0d hashes seen after %0d ns", hashes, issued, RUN_LIMIT_NS);
    $display("test failed");
    $finish;
  end

endmodule

// ==== tests/sha_checker.sv ====
`timescale 1ns/100ps

module sha_checker (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         job_valid_i,
  input  logic [255:0] midstate_i,
  input  logic [31:0]  merkle_tail_i,
  input  logic [31:0]  timestamp_i,
  input  logic [31:0]  bits_i,
  input  logic         run_i,
  input  logic         hash_valid_i,
  input  logic         newblock_i,
  input  logic [255:0] hash_i,
  input  int           test_id_i,
  input  logic         end_test_i,  // One-cycle pulse that closes the current test.
  input  int           issued_i,
  output int           hashes_o,
  output int           errors_o,
  output int           tests_failed_o
);

  localparam logic [31:0] K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };
  localparam logic [255:0] IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };
  // SHA-256 of "abc", the standard one-block test vector.
  localparam logic [511:0] ABC_BLOCK  = {32'h61626380, 448'b0, 32'h00000018};
  localparam logic [255:0] ABC_DIGEST = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };

  logic [351:0] jobs [$];          // Loaded jobs that have not started yet.
  logic [351:0] job;               // {midstate, merkle tail, timestamp, bits}
  logic [31:0]  nonce;
  logic         have_job    = 1'b0;
  logic         started     = 1'b0; // Set once run_i has been high.
  logic         ref_checked = 1'b0;
  int           test_errors;

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "fixed_vector";
      2:       return "continuous_run";
      3:       return "run_gaps";
      4:       return "job_change";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [31:0] ror(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // One SHA-256 block with the final add. W0 is the top word of blk.
  function automatic logic [255:0] compress(input logic [255:0] h_in, input logic [511:0] blk);
    logic [31:0]  w [64];
    logic [31:0]  a, b, c, d, e, f, g, h;
    logic [31:0]  t1, t2;
    logic [255:0] h_out;
    for (int t = 0; t < 16; t++) begin
      w[t] = blk[511 - 32*t -: 32];
    end
    for (int t = 16; t < 64; t++) begin
      w[t] = w[t-16] + w[t-7]
           + (ror(w[t-15], 7) ^ ror(w[t-15], 18) ^ (w[t-15] >> 3))
           + (ror(w[t-2], 17) ^ ror(w[t-2], 19) ^ (w[t-2] >> 10));
    end
    {a, b, c, d, e, f, g, h} = h_in;
    for (int t = 0; t < 64; t++) begin
      t1 = h + (ror(e, 6) ^ ror(e, 11) ^ ror(e, 25)) + ((e & f) ^ (~e & g)) + K[t] + w[t];
      t2 = (ror(a, 2) ^ ror(a, 13) ^ ror(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
      h = g;
      g = f;
      f = e;
      e = d + t1;
      d = c;
      c = b;
      b = a;
      a = t1 + t2;
    end
    h_out = {a, b, c, d, e, f, g, h};
    for (int i = 0; i < 8; i++) begin
      h_out[32*i +: 32] = h_out[32*i +: 32] + h_in[32*i +: 32];
    end
    return h_out;
  endfunction

  // Second chunk of the 80-byte header, then the padded 32-byte digest.
  function automatic logic [255:0] sha256d(input logic [351:0] j, input logic [31:0] n);
    logic [255:0] digest;
    digest = compress(j[351:96], {j[95:0], n, 32'h80000000, 320'b0, 32'd640});
    return compress(IV, {digest, 32'h80000000, 192'b0, 32'd256});
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name(test_id_i), msg);
    errors_o++;
    test_errors++;
  endtask

  always @(negedge clk) begin
    logic [255:0] exp_hash;
    if (rst_n_i) begin
      if (!ref_checked && compress(IV, ABC_BLOCK) !== ABC_DIGEST) begin
        report_error("the reference model gets the abc test vector wrong");
      end
      ref_checked = 1'b1;
      if (!started && (hash_valid_i !== 1'b0 || newblock_i !== 1'b0)) begin
        report_error("hash_valid_o or newblock_o active before the first run");
      end
      if (run_i) started = 1'b1;
      if (job_valid_i) jobs.push_back({midstate_i, merkle_tail_i, timestamp_i, bits_i});
      if (newblock_i && !hash_valid_i) report_error("newblock_o high without hash_valid_o");
      if (hash_valid_i) begin
        hashes_o++;
        if (newblock_i) begin
          if (jobs.size() == 0) begin
            report_error("newblock_o with no loaded job waiting");
          end else begin
            job = jobs.pop_front(); // The next job starts over at nonce zero.
            have_job = 1'b1;
            nonce = '0;
          end
        end else begin
          nonce = nonce + 32'd1;
        end
        if (!have_job) begin
          report_error("hash_valid_o before any newblock_o");
        end else begin
          exp_hash = sha256d(job, nonce);
          if (hash_i !== exp_hash) begin
            $display("FAIL %s nonce %0d expected %h actual %h",
                     test_name(test_id_i), nonce, exp_hash, hash_i);
            errors_o++;
            test_errors++;
          end
        end
      end
      if (end_test_i) begin
        if (hashes_o != issued_i) begin
          report_error($sformatf("%0d hashes seen for %0d issued nonces", hashes_o, issued_i));
        end
        if (jobs.size() != 0) report_error("a loaded job never produced a newblock_o hash");
        if (test_errors == 0) begin
          $display("%s: ok, %0d hashes checked so far", test_name(test_id_i), hashes_o);
        end else begin
          $display("%s: %0d errors", test_name(test_id_i), test_errors);
          tests_failed_o++;
        end
        test_errors = 0;
      end
    end
  end

endmodule

// ==== verilog/sha_miner_top.sv ====
`timescale 1ns/100ps

module sha_miner_top (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         job_valid_i,   // Loads all four job words at once.
  input  logic [255:0] midstate_i,
  input  logic [31:0]  merkle_tail_i,
  input  logic [31:0]  timestamp_i,
  input  logic [31:0]  bits_i,
  input  logic         run_i,         // One nonce per cycle while high.
  output logic         hash_valid_o,
  output logic         newblock_o,
  output logic [255:0] hash_o
);

  logic [255:0] midstate_dly;
  logic [31:0]  timestamp;
  logic [31:0]  bits;

  sha_stage_if front_link ();

  sha_midstate_front u_front (
    .clk, .rst_n_i, .job_valid_i, .midstate_i, .merkle_tail_i, .timestamp_i, .bits_i, .run_i,
    .out            (front_link),
    .midstate_dly_o (midstate_dly),
    .timestamp_o    (timestamp),
    .bits_o         (bits)
  );

  sha_super_pipelined_core u_core (
    .clk, .rst_n_i, .in(front_link), .midstate_dly_i(midstate_dly),
    .timestamp_i (timestamp),
    .bits_i      (bits),
    .hash_valid_o, .newblock_o, .hash_o
  );

endmodule

// ==== verilog/sha_super_pipelined_core.sv ====
`timescale 1ns/100ps

module sha_super_pipelined_core (
  input  logic               clk,
  input  logic               rst_n_i,
  sha_stage_if.snk           in,
  input  sha_pkg::HashState  midstate_dly_i,
  input  sha_pkg::word_t     timestamp_i,
  input  sha_pkg::word_t     bits_i,
  output logic               hash_valid_o,
  output logic               newblock_o,
  output sha_pkg::HashState  hash_o
);

  // Link k of each chain feeds the stage that runs round k.
  sha_stage_if h1_link [sha_pkg::ROUNDS:sha_pkg::PRE_ROUNDS] ();
  sha_stage_if h2_link [sha_pkg::ROUNDS:0] ();

  // Rounds 1 to 14 of the first hash, with the header words fed in directly.
  sha_super_pipelined_pre_pipeline u_pre (
    .clk,
    .rst_n_i,
    .timestamp_i,
    .bits_i,
    .in  (in),
    .out (h1_link[sha_pkg::PRE_ROUNDS])
  );

  for (genvar i = sha_pkg::PRE_ROUNDS; i < sha_pkg::ROUNDS; i++) begin : g_hash1
    sha_super_pipelined_stage #(.ROUND(i)) u_stage (
      .clk, .rst_n_i, .in(h1_link[i]), .out(h1_link[i+1])
    );
  end

  // Finish the first hash and pad its digest into the second block.
  sha_super_pipelined_pad_hash u_pad (
    .clk,
    .rst_n_i,
    .in         (h1_link[sha_pkg::ROUNDS]),
    .midstate_i (midstate_dly_i),
    .out        (h2_link[0])
  );

  // Early second-hash rounds read the block words in place.
  for (genvar i = 0; i < sha_pkg::PRE_ROUNDS; i++) begin : g_hash2_pre
    sha_super_pipelined_preserve_history_stage #(.ROUND(i)) u_stage (
      .clk, .rst_n_i, .in(h2_link[i]), .out(h2_link[i+1])
    );
  end

  for (genvar i = sha_pkg::PRE_ROUNDS; i < sha_pkg::ROUNDS; i++) begin : g_hash2
    sha_super_pipelined_stage #(.ROUND(i)) u_stage (
      .clk, .rst_n_i, .in(h2_link[i]), .out(h2_link[i+1])
    );
  end

  assign hash_o       = sha_pkg::sha_add_state(h2_link[sha_pkg::ROUNDS].state, sha_pkg::SHA_IV);
  assign hash_valid_o = h2_link[sha_pkg::ROUNDS].valid;
  assign newblock_o   = h2_link[sha_pkg::ROUNDS].newblock;

endmodule

// ==== verilog/sha_super_pipelined_pad_hash.sv ====
`timescale 1ns/100ps

module sha_super_pipelined_pad_hash (
  input  logic              clk,
  input  logic              rst_n_i,
  sha_stage_if.snk          in,
  input  sha_pkg::HashState midstate_i,
  sha_stage_if.src          out
);

  sha_pkg::HashState digest; // First SHA-256 result.
  sha_pkg::history_t block;  // Padded 32-byte message for the second hash.

  assign digest = sha_pkg::sha_add_state(in.state, midstate_i);

  always_comb begin
    block = '0;
    // Digest word a becomes W0, so the order flips against the state layout.
    for (int i = 0; i < 8; i++) begin
      block[32*i +: 32] = digest[255 - 32*i -: 32];
    end
    block[256 +: 32] = 32'h80000000; // Padding marker in W8.
    block[480 +: 32] = 32'd256;      // Message length in bits.
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out.valid    <= 1'b0;
      out.newblock <= 1'b0;
    end else begin
      out.valid    <= in.valid;
      out.newblock <= in.newblock;
    end
  end

  always_ff @(posedge clk) begin
    out.state   <= sha_pkg::SHA_IV; // The second hash starts from the standard IV.
    out.history <= block;
  end

endmodule

// ==== verilog/sha_super_pipelined_preserve_history_stage.sv ====
`timescale 1ns/100ps

module sha_super_pipelined_preserve_history_stage #(
  parameter int ROUND = 0
) (
  input  logic     clk,
  input  logic     rst_n_i,
  sha_stage_if.snk in,
  sha_stage_if.src out
);

  sha_pkg::word_t w_cur;

  // The padded block already holds W0 to W15, so the round just picks its word.
  assign w_cur = in.history[32*ROUND +: 32];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out.valid    <= 1'b0;
      out.newblock <= 1'b0;
    end else begin
      out.valid    <= in.valid;
      out.newblock <= in.newblock;
    end
  end

  always_ff @(posedge clk) begin
    out.state   <= sha_pkg::sha_round(in.state, w_cur, sha_pkg::Kfunction(ROUND));
    out.history <= in.history; // Kept whole for the expander stages.
  end

endmodule

// ==== verilog/sha_super_pipelined_stage.sv ====
`timescale 1ns/100ps

module sha_super_pipelined_stage #(
  parameter int ROUND = 15
) (
  input  logic     clk,
  input  logic     rst_n_i,
  sha_stage_if.snk in,
  sha_stage_if.src out
);

  sha_pkg::word_t w_cur;  // W[ROUND], the newest history word.
  sha_pkg::word_t w_next; // W[ROUND+1] from the expander.

  assign w_cur  = in.history[480 +: 32];
  assign w_next = sha_pkg::sha_expand(in.history);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out.valid    <= 1'b0;
      out.newblock <= 1'b0;
    end else begin
      out.valid    <= in.valid;
      out.newblock <= in.newblock;
    end
  end

  // Payload moves every cycle. Bubbles carry stale data that nobody reads.
  always_ff @(posedge clk) begin
    out.state   <= sha_pkg::sha_round(in.state, w_cur, sha_pkg::Kfunction(ROUND));
    out.history <= {w_next, in.history[511:32]}; // The oldest word falls out.
  end

endmodule

// ==== verilog/sha_super_pipelined_pre_pipeline.sv ====
`timescale 1ns/100ps

module sha_super_pipelined_pre_pipeline (
  input  logic           clk,
  input  logic           rst_n_i,
  input  sha_pkg::word_t timestamp_i,
  input  sha_pkg::word_t bits_i,
  sha_stage_if.snk       in,
  sha_stage_if.src       out
);

  localparam int LAST = sha_pkg::PRE_ROUNDS - 1;   // Round 14 is the last one here.
  localparam sha_pkg::word_t LEN_BITS = 32'd640;   // Block header length, used as W15.

  // Per-item words that are not constant: timestamp, bits and nonce.
  typedef logic [95:0] row_t;

  sha_pkg::nonce_t   nonce_q;
  sha_pkg::nonce_t   item_nonce;
  logic              valid_p   [1:sha_pkg::PRE_ROUNDS];
  logic              newblk_p  [1:sha_pkg::PRE_ROUNDS];
  sha_pkg::HashState state_p   [1:sha_pkg::PRE_ROUNDS];
  sha_pkg::history_t hist_p    [1:sha_pkg::PRE_ROUNDS];
  row_t              row_p     [1:LAST];

  // Message word of round r. Words after the nonce are padding.
  function automatic sha_pkg::word_t msg_word(input int r, input row_t row);
    case (r)
      1:       return row[95:64];
      2:       return row[63:32];
      3:       return row[31:0];
      4:       return 32'h80000000;
      default: return '0;
    endcase
  endfunction

  assign item_nonce = in.newblock ? '0 : nonce_q; // A new job starts again at nonce zero.

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      nonce_q <= '0;
    end else if (in.valid) begin
      nonce_q <= item_nonce + 32'd1;
    end
  end

  // Stage 1 samples the job words, so later stages never look at the job registers.
  assign valid_p[1]  = in.valid;
  assign newblk_p[1] = in.newblock;
  assign state_p[1]  = in.state;
  assign hist_p[1]   = in.history;
  assign row_p[1]    = {timestamp_i, bits_i, item_nonce};

  for (genvar r = 1; r <= LAST; r++) begin : g_round
    sha_pkg::word_t w;
    assign w = msg_word(r, row_p[r]);

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        valid_p[r+1]  <= 1'b0;
        newblk_p[r+1] <= 1'b0;
      end else begin
        valid_p[r+1]  <= valid_p[r];
        newblk_p[r+1] <= newblk_p[r];
      end
    end

    always_ff @(posedge clk) begin
      state_p[r+1] <= sha_pkg::sha_round(state_p[r], w, sha_pkg::Kfunction(r));
      if (r == LAST) begin
        hist_p[r+1] <= {LEN_BITS, w, hist_p[r][511:64]}; // W14 and W15 go in together.
      end else begin
        hist_p[r+1] <= {w, hist_p[r][511:32]};
      end
    end

    // The row moves with its item so each round sees its own job words.
    if (r < LAST) begin : g_row
      always_ff @(posedge clk) begin
        row_p[r+1] <= row_p[r];
      end
    end
  end

  assign out.valid    = valid_p[sha_pkg::PRE_ROUNDS];
  assign out.newblock = newblk_p[sha_pkg::PRE_ROUNDS];
  assign out.state    = state_p[sha_pkg::PRE_ROUNDS];   // State after rounds 0 to 14.
  assign out.history  = hist_p[sha_pkg::PRE_ROUNDS];    // W0 to W15 of chunk two.

  // The nonce restart relies on the front only flagging real items.
  a_newblock_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    in.newblock |-> in.valid);

endmodule

// ==== verilog/sha_midstate_front.sv ====
`timescale 1ns/100ps

module sha_midstate_front (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               job_valid_i,
  input  sha_pkg::HashState  midstate_i,
  input  sha_pkg::word_t     merkle_tail_i,
  input  sha_pkg::word_t     timestamp_i,
  input  sha_pkg::word_t     bits_i,
  input  logic               run_i,
  sha_stage_if.src           out,
  output sha_pkg::HashState  midstate_dly_o,
  output sha_pkg::word_t     timestamp_o,
  output sha_pkg::word_t     bits_o
);

  sha_pkg::HashState midstate_q;
  sha_pkg::word_t    merkle_q;
  sha_pkg::word_t    timestamp_q;
  sha_pkg::word_t    bits_q;
  logic              job_loaded_q;
  logic              new_pending_q;            // Next issued item opens a new job.
  logic              issue;
  sha_pkg::HashState mid_dly_q [sha_pkg::ROUNDS];

  // The load cycle itself issues nothing, so every item sees one consistent job.
  assign issue = run_i & job_loaded_q & ~job_valid_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      job_loaded_q  <= 1'b0;
      new_pending_q <= 1'b0;
      out.valid     <= 1'b0;
      out.newblock  <= 1'b0;
    end else begin
      out.valid    <= issue;
      out.newblock <= issue & new_pending_q;
      if (job_valid_i) begin
        job_loaded_q  <= 1'b1;
        new_pending_q <= 1'b1;                 // Armed again by every load.
      end else if (issue) begin
        new_pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (job_valid_i) begin
      midstate_q  <= midstate_i;
      merkle_q    <= merkle_tail_i;
      timestamp_q <= timestamp_i;
      bits_q      <= bits_i;
    end
    // Round 0 uses the merkle tail as W0, which then becomes the newest history word.
    out.state   <= sha_pkg::sha_round(midstate_q, merkle_q, sha_pkg::Kfunction(0));
    out.history <= {merkle_q, 480'b0};
    // The delay line runs every cycle so the midstate stays in step with its item.
    mid_dly_q[0] <= midstate_q;
    for (int i = 1; i < sha_pkg::ROUNDS; i++) begin
      mid_dly_q[i] <= mid_dly_q[i-1];
    end
  end

  assign midstate_dly_o = mid_dly_q[sha_pkg::ROUNDS-1]; // Meets the item at the pad stage.
  assign timestamp_o    = timestamp_q;
  assign bits_o         = bits_q;

  // Starting a run without a job would push garbage into the pipeline.
  a_run_needs_job: assert property (@(posedge clk) disable iff (!rst_n_i)
    run_i |-> job_loaded_q);

endmodule

// ==== verilog/sha_stage_if.sv ====
`timescale 1ns/100ps

// Link between two registered pipeline stages. There is no handshake.
interface sha_stage_if;
  logic valid;                // Item present in this slot.
  logic newblock;             // First item of a job, only ever high with valid.
  sha_pkg::HashState state;   // Working words a..h.
  sha_pkg::history_t history; // Sixteen most recent message words.

  modport src (
    output valid, newblock, state, history
  );

  modport snk (
    input valid, newblock, state, history
  );
endinterface

// ==== verilog/sha_pkg.sv ====
package sha_pkg;

  // One 32-bit SHA-256 word.
  typedef logic [31:0] word_t;
  // Working words a..h, with a in the top 32 bits.
  typedef logic [255:0] HashState;
  // Sixteen message words. Word i sits at bits [32*i +: 32] and word 15 is the newest.
  typedef logic [511:0] history_t;
  typedef logic [31:0] nonce_t;

  localparam int ROUNDS = 64;     // Rounds in one compression.
  localparam int PRE_ROUNDS = 15; // Rounds fed straight from the block words.

  // Standard starting state of a fresh SHA-256 hash.
  localparam HashState SHA_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  localparam word_t K_TABLE [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Round constant for round idx. The index is always a generate constant.
  function automatic word_t Kfunction(input int idx);
    return K_TABLE[idx];
  endfunction

  function automatic word_t rotr(input word_t x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // One compression round on state s with message word w and constant k.
  function automatic HashState sha_round(input HashState s, input word_t w, input word_t k);
    word_t a, b, c, d, e, f, g, h;
    word_t t1, t2;
    {a, b, c, d, e, f, g, h} = s;
    t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g)) + k + w;
    t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
    return {t1 + t2, a, b, c, d + t1, e, f, g};
  endfunction

  // Next message word from the last sixteen. Word 0 is W[t-16] and word 14 is W[t-2].
  function automatic word_t sha_expand(input history_t hist);
    word_t w0, w1, w9, w14;
    w0 = hist[0 +: 32];
    w1 = hist[32 +: 32];
    w9 = hist[288 +: 32];
    w14 = hist[448 +: 32];
    return (rotr(w14, 17) ^ rotr(w14, 19) ^ (w14 >> 10)) + w9
         + (rotr(w1, 7) ^ rotr(w1, 18) ^ (w1 >> 3)) + w0;
  endfunction

  // Word-wise add modulo 2**32, as used after each compression.
  function automatic HashState sha_add_state(input HashState x, input HashState y);
    HashState sum;
    for (int i = 0; i < 8; i++) begin
      sum[32*i +: 32] = x[32*i +: 32] + y[32*i +: 32];
    end
    return sum;
  endfunction

endpackage
